//--- all.f
+incdir+verilog
verilog/core_pkg.sv
verilog/reg_read_if.sv
verilog/regfile.sv
verilog/program_counter.sv
verilog/decoder.sv
verilog/execute.sv
verilog/memory.sv
verilog/writeback.sv
verilog/datapath.sv
testbench/datapath_properties.sv
testbench/datapath_tb.sv

//--- testbench/datapath_properties.sv
module datapath_properties import corePkg::*; (
    input logic clk,
    input logic rstN,
    input logic ireqValid,
    input u64 ireqAddr,
    input logic irespOk,
    input logic dreqValid,
    input logic dreqWrite,
    input u64 dreqAddr,
    input u64 dreqData,
    input logic drespOk,
    input logic commitValid,
    input u5 commitRd,
    input logic commitWrite
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;

    // A fetch keeps its address until the instruction word comes back.
    ireqSteady: assert property (@(posedge clk) disable iff (!rstN)
        ireqValid && !irespOk |=> ireqValid && $stable(ireqAddr))
    else begin
        failCount++;
        $error("instruction request changed before its response");
    end

    dreqSteady: assert property (@(posedge clk) disable iff (!rstN)
        dreqValid && !drespOk |=> dreqValid && $stable({dreqWrite, dreqAddr, dreqData}))
    else begin
        failCount++;
        $error("data request changed before its response");
    end

    commitQuietInReset: assert property (@(posedge clk) !rstN |=> !commitValid)
    else begin
        failCount++;
        $error("commit seen during reset");
    end

    commitQuietAfterReset: assert property (@(posedge clk) $rose(rstN) |=> !commitValid)
    else begin
        failCount++;
        $error("commit seen in the first cycle after reset");
    end

    // Nothing retires into x0.
    zeroRdNoWrite: assert property (@(posedge clk) disable iff (!rstN)
        commitValid && commitRd == 5'd0 |-> !commitWrite)
    else begin
        failCount++;
        $error("commit to x0 has its write flag set");
    end

endmodule

bind datapath datapath_properties props_inst (
    .clk(clk), .rstN(rstN),
    .ireqValid(ireqValid), .ireqAddr(ireqAddr), .irespOk(irespOk),
    .dreqValid(dreqValid), .dreqWrite(dreqWrite), .dreqAddr(dreqAddr),
    .dreqData(dreqData), .drespOk(drespOk),
    .commitValid(commitValid), .commitRd(commitRd), .commitWrite(commitWrite)
);

//--- testbench/datapath_tb.sv
`include "core_consts.svh"

module datapath_tb import corePkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS = 20;
    localparam int MAX_WAIT = 3;
    localparam logic [9:0] FN_ADD = {7'b0000000, 3'b000};
    localparam logic [9:0] FN_SUB = {7'b0100000, 3'b000};
    localparam logic [9:0] FN_AND = {7'b0000000, 3'b111};
    localparam logic [9:0] FN_OR = {7'b0000000, 3'b110};
    localparam logic [9:0] FN_XOR = {7'b0000000, 3'b100};

    logic clk;
    logic rstN;
    logic ireqValid;
    u64 ireqAddr;
    logic irespOk;
    u32 irespData;
    logic dreqValid;
    logic dreqWrite;
    u64 dreqAddr;
    u64 dreqData;
    logic drespOk;
    u64 drespData;
    logic commitValid;
    u64 commitPc;
    u5 commitRd;
    logic commitWrite;
    u64 commitData;

    u32 imem [64];
    u64 dmem [16];
    u64 goldMem [16];
    u32 prog [$];
    int progTest [$];
    string testNames [$];
    u64 expPc [$];
    u5 expRd [$];
    logic expWrite [$];
    u64 expData [$];
    int expTest [$];
    int unsigned lcgState = 32'h837e3d5b;
    int nChecked = 0;
    int errCount = 0;
    int testErrStart = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    int iWait = -1;
    int dWait = -1;

    datapath datapath_inst (
        .clk(clk), .rstN(rstN),
        .ireqValid(ireqValid), .ireqAddr(ireqAddr),
        .irespOk(irespOk), .irespData(irespData),
        .dreqValid(dreqValid), .dreqWrite(dreqWrite),
        .dreqAddr(dreqAddr), .dreqData(dreqData),
        .drespOk(drespOk), .drespData(drespData),
        .commitValid(commitValid), .commitPc(commitPc), .commitRd(commitRd),
        .commitWrite(commitWrite), .commitData(commitData)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState >> 16;
    endfunction

    // Encoders follow the RV64I base formats.
    function automatic u32 addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], `OP_IMM};
    endfunction

    function automatic u32 ld(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b011, rd[4:0], `OP_LOAD};
    endfunction

    function automatic u32 sd(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], `OP_STORE};
    endfunction

    function automatic u32 beq(input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11], `OP_BRANCH};
    endfunction

    function automatic u32 jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `OP_JAL};
    endfunction

    function automatic u32 regOp(input logic [9:0] fn, input int rd, input int rs1, input int rs2);
        return {fn[9:3], rs2[4:0], rs1[4:0], fn[2:0], rd[4:0], `OP_REG};
    endfunction

    function automatic u64 iImm(input u32 ins);
        return {{52{ins[31]}}, ins[31:20]};
    endfunction

    function automatic u64 sImm(input u32 ins);
        return {{52{ins[31]}}, ins[31:25], ins[11:7]};
    endfunction

    function automatic u64 bImm(input u32 ins);
        return {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    endfunction

    function automatic u64 jImm(input u32 ins);
        return {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    endfunction

    // Unused words hold ADDI x0, x0, index so stray fetches do nothing.
    function automatic u32 fillWord(input int idx);
        return {idx[11:0], 5'd0, 3'b000, 5'd0, `OP_IMM};
    endfunction

    task automatic startTest(input string name);
        testNames.push_back(name);
    endtask

    task automatic emit(input u32 word);
        prog.push_back(word);
        progTest.push_back(testNames.size() - 1);
    endtask

    task automatic buildProgram();
        startTest("alu forwarding");
        emit(addi(1, 0, 100));
        emit(addi(2, 1, -7));
        emit(regOp(FN_ADD, 3, 1, 2));
        emit(regOp(FN_SUB, 4, 3, 1));
        emit(regOp(FN_XOR, 5, 4, 2));
        emit(regOp(FN_AND, 6, 5, 3));
        emit(regOp(FN_OR, 7, 6, 4));
        emit(addi(8, 7, 2047));
        startTest("load use hold");
        emit(addi(10, 0, 16));
        emit(ld(11, 10, 0));
        emit(regOp(FN_ADD, 12, 11, 1));
        emit(ld(13, 10, 8));
        emit(addi(14, 13, -1));
        emit(regOp(FN_ADD, 15, 13, 14));
        startTest("taken branch and jump");
        emit(addi(16, 0, 5));
        emit(addi(17, 0, 5));
        emit(beq(16, 17, 12));
        emit(addi(18, 0, 1));
        emit(addi(18, 0, 2));
        emit(jal(19, 12));
        emit(addi(20, 0, 3));
        emit(addi(20, 0, 4));
        emit(regOp(FN_ADD, 21, 19, 16));
        startTest("branch not taken");
        emit(addi(22, 0, 9));
        emit(beq(22, 16, 8));
        emit(addi(23, 22, 1));
        emit(beq(23, 0, 8));
        emit(addi(24, 23, 1));
        startTest("store then load");
        emit(addi(25, 10, 24));
        emit(sd(8, 25, 0));
        emit(ld(26, 25, 0));
        emit(sd(26, 25, -8));
        emit(ld(27, 25, -8));
        emit(regOp(FN_ADD, 28, 27, 26));
        startTest("x0 writes");
        emit(addi(0, 0, 77));
        emit(regOp(FN_ADD, 29, 0, 0));
        emit(ld(0, 10, 0));
        emit(addi(30, 0, 3));
        emit(regOp(FN_ADD, 0, 1, 2));
        emit(regOp(FN_OR, 31, 0, 30));
        // The program ends in a jump to itself.
        emit(jal(0, 0));
        foreach (imem[i]) begin
            imem[i] = (i < prog.size()) ? prog[i] : fillWord(i);
        end
        foreach (dmem[i]) begin
            dmem[i] = 64'h5a5a_0000_0000_0000 | (64'(i) * 64'h0001_0203_0405_0607);
            goldMem[i] = dmem[i];
        end
    endtask

    // Runs the program in order and records every commit it expects.
    task automatic runGolden();
        u64 x [32];
        u64 pc;
        u64 nextPc;
        u64 a;
        u64 b;
        u64 val;
        u64 addr;
        u32 ins;
        logic wr;
        int steps;
        pc = `RESET_PC;
        steps = 0;
        foreach (x[i]) begin
            x[i] = '0;
        end
        while (steps < 500) begin
            ins = prog[pc >> 2];
            a = x[ins[19:15]];
            b = x[ins[24:20]];
            nextPc = pc + 64'd4;
            wr = 1'b0;
            val = '0;
            case (ins[6:0])
                `OP_REG: begin
                    wr = 1'b1;
                    case ({ins[31:25], ins[14:12]})
                        FN_SUB: val = a - b;
                        FN_AND: val = a & b;
                        FN_OR: val = a | b;
                        FN_XOR: val = a ^ b;
                        default: val = a + b;
                    endcase
                end
                `OP_IMM: begin
                    wr = 1'b1;
                    val = a + iImm(ins);
                end
                `OP_LOAD: begin
                    wr = 1'b1;
                    addr = a + iImm(ins);
                    val = goldMem[addr[6:3]];
                end
                `OP_STORE: begin
                    addr = a + sImm(ins);
                    goldMem[addr[6:3]] = b;
                end
                `OP_BRANCH: begin
                    if (a == b) begin
                        nextPc = pc + bImm(ins);
                    end
                end
                `OP_JAL: begin
                    wr = 1'b1;
                    val = pc + 64'd4;
                    nextPc = pc + jImm(ins);
                end
                default: ;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                x[ins[11:7]] = val;
            end
            expPc.push_back(pc);
            expRd.push_back(ins[11:7]);
            expWrite.push_back(wr && ins[11:7] != 5'd0);
            expData.push_back(val);
            expTest.push_back(progTest[pc >> 2]);
            if ((pc >> 2) == prog.size() - 1) begin
                break;
            end
            pc = nextPc;
            steps++;
        end
    endtask

    task automatic checkValue(input string name, input u64 expected, input u64 actual);
        assert (expected === actual) else begin
            $display("mismatch at %0d ns: %s expected %h actual %h",
                     $time, name, expected, actual);
            errCount++;
        end
    endtask

    task automatic finishTest(input string name);
        if (errCount == testErrStart) begin
            testsPassed++;
            $display("%0d ns: test %s passed", $time, name);
        end else begin
            testsFailed++;
            $display("%0d ns: test %s failed with %0d errors",
                     $time, name, errCount - testErrStart);
        end
        testErrStart = errCount;
    endtask

    task automatic checkCommit();
        int k;
        k = nChecked;
        checkValue("commitPc", expPc[k], commitPc);
        checkValue("commitWrite", expWrite[k], commitWrite);
        if (expWrite[k]) begin
            checkValue("commitRd", expRd[k], commitRd);
            checkValue("commitData", expData[k], commitData);
        end
        nChecked++;
        if (nChecked == expPc.size() || expTest[nChecked] != expTest[k]) begin
            finishTest(testNames[expTest[k]]);
        end
    endtask

    // Both buses answer after 0 to MAX_WAIT cycles.
    initial begin
        forever begin
            @(posedge clk);
            #2;
            irespOk = 1'b0;
            drespOk = 1'b0;
            if (rstN && ireqValid) begin
                if (iWait < 0) begin
                    iWait = nextRand() % (MAX_WAIT + 1);
                end
                if (iWait == 0) begin
                    irespOk = 1'b1;
                    irespData = imem[ireqAddr[7:2]];
                end
                iWait--;
            end
            if (rstN && dreqValid) begin
                if (dWait < 0) begin
                    dWait = nextRand() % (MAX_WAIT + 1);
                end
                if (dWait == 0) begin
                    drespOk = 1'b1;
                    if (dreqWrite) begin
                        dmem[dreqAddr[6:3]] = dreqData;
                    end else begin
                        drespData = dmem[dreqAddr[6:3]];
                    end
                end
                dWait--;
            end
        end
    end

    always @(negedge clk) begin
        if (rstN === 1'b1 && commitValid === 1'b1 && nChecked < expPc.size()) begin
            checkCommit();
        end
    end

    initial begin
        int limitCycles;
        #1;
        limitCycles = prog.size() * 40 + 200;
        #(limitCycles * CLK_NS);
        $display("timeout: pipeline stopped committing after %0d of %0d commits",
                 nChecked, expPc.size());
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int propFails;
        rstN = 1'b0;
        irespOk = 1'b0;
        irespData = '0;
        drespOk = 1'b0;
        drespData = '0;
        buildProgram();
        runGolden();
        repeat (2) @(posedge clk);
        #2;
        rstN = 1'b1;
        wait (nChecked == expPc.size());
        @(negedge clk);
        foreach (dmem[i]) begin
            checkValue($sformatf("dmem[%0d]", i), goldMem[i], dmem[i]);
        end
        finishTest("data image");
        propFails = datapath_inst.props_inst.failCount;
        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 testsPassed, testsFailed, propFails);
        if (testsFailed == 0 && propFails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath and instruction widths.
`define XLEN 64
`define ILEN 32

// First address fetched after reset.
`define RESET_PC 64'h0

// Major opcodes of the supported instructions.
`define OP_REG    7'b0110011
`define OP_IMM    7'b0010011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111

// ADDI x0, x0, 0 fills a flushed fetch slot.
`define NOP_INSTR 32'h0000_0013

`endif

//--- verilog/core_pkg.sv
`include "core_consts.svh"

package corePkg;

    typedef logic [`XLEN-1:0] u64;
    typedef logic [`ILEN-1:0] u32;
    typedef logic [4:0] u5;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } aluOp_t;

    typedef struct packed {
        logic valid;
        u64 pc;
        u32 instr;
    } regIfId_t;

    typedef struct packed {
        logic valid;
        u64 pc;
        u5 rd;
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic isBranch;
        logic isJal;
        aluOp_t aluOp;
        logic useImm;
        u64 op1;
        u64 op2;
        u64 storeData;
        u64 imm;
    } regIdEx_t;

    typedef struct packed {
        logic valid;
        u64 pc;
        u5 rd;
        logic regWrite;
        logic memRead;
        logic memWrite;
        u64 aluResult;
        u64 storeData;
    } regExMem_t;

    typedef struct packed {
        logic valid;
        u64 pc;
        u5 rd;
        logic regWrite;
        u64 result;
    } regMemWb_t;

    // A stage result that decode may take before it reaches the register file.
    typedef struct packed {
        logic valid;
        u5 rd;
        u64 data;
        logic isLoad;
    } fwdSource_t;

    typedef struct packed {
        logic valid;
        u64 pc;
        u5 rd;
        logic regWrite;
        u64 data;
    } commit_t;

endpackage

//--- verilog/datapath.sv
module datapath import corePkg::*; (
    input logic clk,
    input logic rstN,
    output logic ireqValid,
    output u64 ireqAddr,
    input logic irespOk,
    input u32 irespData,
    output logic dreqValid,
    output logic dreqWrite,
    output u64 dreqAddr,
    output u64 dreqData,
    input logic drespOk,
    input u64 drespData,
    output logic commitValid,
    output u64 commitPc,
    output u5 commitRd,
    output logic commitWrite,
    output u64 commitData
);

    regIfId_t ifId;
    regIdEx_t idEx;
    regExMem_t exMem;
    regMemWb_t memWb;
    fwdSource_t fwdEx;
    fwdSource_t fwdMem;
    commit_t commit;

    logic wbEn;
    u5 wd;
    u64 wbData;
    logic lwHold;
    logic jumpEn;
    u64 jumpAddr;
    logic okFetch, okDecode, okExecute, okMemory, okWriteback;
    logic okAll;

    regReadIf regRead ();

    // Every stage advances together, or none does.
    assign okAll = okFetch & okDecode & okExecute & okMemory & okWriteback;

    assign commitValid = commit.valid;
    assign commitPc = commit.pc;
    assign commitRd = commit.rd;
    assign commitWrite = commit.regWrite;
    assign commitData = commit.data;

    regfile regfile_inst (
        .clk(clk), .rstN(rstN), .rd(regRead.server),
        .wbEn(wbEn), .wd(wd), .wbData(wbData)
    );

    programCounter pc_inst (
        .clk(clk), .rstN(rstN), .lwHold(lwHold), .okAll(okAll),
        .jumpEn(jumpEn), .jumpAddr(jumpAddr),
        .ireqValid(ireqValid), .ireqAddr(ireqAddr),
        .irespOk(irespOk), .irespData(irespData),
        .okToProceed(okFetch), .moduleOut(ifId)
    );

    decoder decoder_inst (
        .clk(clk), .rstN(rstN), .okAll(okAll), .jumpEn(jumpEn),
        .moduleIn(ifId), .moduleOut(idEx), .rd(regRead.client),
        .fwdEx(fwdEx), .fwdMem(fwdMem), .lwHold(lwHold),
        .okToProceed(okDecode)
    );

    execute execute_inst (
        .clk(clk), .rstN(rstN), .okAll(okAll),
        .moduleIn(idEx), .moduleOut(exMem), .fwdEx(fwdEx),
        .jumpEn(jumpEn), .jumpAddr(jumpAddr), .okToProceed(okExecute)
    );

    memory memory_inst (
        .clk(clk), .rstN(rstN), .okAll(okAll),
        .moduleIn(exMem), .moduleOut(memWb), .fwdMem(fwdMem),
        .dreqValid(dreqValid), .dreqWrite(dreqWrite),
        .dreqAddr(dreqAddr), .dreqData(dreqData),
        .drespOk(drespOk), .drespData(drespData),
        .okToProceed(okMemory)
    );

    writeback writeback_inst (
        .clk(clk), .rstN(rstN), .okAll(okAll), .moduleIn(memWb),
        .wbEn(wbEn), .wd(wd), .wbData(wbData),
        .commit(commit), .okToProceed(okWriteback)
    );

endmodule

//--- verilog/decoder.sv
`include "core_consts.svh"

module decoder import corePkg::*; (
    input logic clk,
    input logic rstN,
    input logic okAll,
    input logic jumpEn,
    input regIfId_t moduleIn,
    output regIdEx_t moduleOut,
    regReadIf.client rd,
    input fwdSource_t fwdEx,
    input fwdSource_t fwdMem,
    output logic lwHold,
    output logic okToProceed
);

    u32 instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    u5 rdAddr;
    u5 rs1Addr;
    u5 rs2Addr;
    logic usesRs1;
    logic usesRs2;
    logic supported;
    regIdEx_t next;

    assign instr = moduleIn.instr;
    assign opcode = instr[6:0];
    assign rdAddr = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];
    assign funct7 = instr[31:25];

    assign rd.rs1 = rs1Addr;
    assign rd.rs2 = rs2Addr;
    assign okToProceed = 1'b1;

    // The youngest producer wins.
    function automatic u64 pickOperand(input u5 addr, input u64 fileData);
        if (fwdEx.valid && fwdEx.rd != 5'd0 && fwdEx.rd == addr) begin
            return fwdEx.data;
        end
        if (fwdMem.valid && fwdMem.rd != 5'd0 && fwdMem.rd == addr) begin
            return fwdMem.data;
        end
        return fileData;
    endfunction

    assign usesRs1 = opcode inside {`OP_REG, `OP_IMM, `OP_LOAD, `OP_STORE, `OP_BRANCH};
    assign usesRs2 = opcode inside {`OP_REG, `OP_STORE, `OP_BRANCH};

    assign lwHold = moduleIn.valid && fwdEx.valid && fwdEx.isLoad && fwdEx.rd != 5'd0
        && ((usesRs1 && fwdEx.rd == rs1Addr) || (usesRs2 && fwdEx.rd == rs2Addr));

    always_comb begin
        next = '0;
        next.pc = moduleIn.pc;
        next.rd = rdAddr;
        next.aluOp = ALU_ADD;
        next.op1 = pickOperand(rs1Addr, rd.rs1Data);
        next.op2 = pickOperand(rs2Addr, rd.rs2Data);
        next.storeData = next.op2;
        supported = 1'b0;
        case (opcode)
            `OP_REG: begin
                supported = 1'b1;
                next.regWrite = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: next.aluOp = ALU_ADD;
                    {7'b0100000, 3'b000}: next.aluOp = ALU_SUB;
                    {7'b0000000, 3'b111}: next.aluOp = ALU_AND;
                    {7'b0000000, 3'b110}: next.aluOp = ALU_OR;
                    {7'b0000000, 3'b100}: next.aluOp = ALU_XOR;
                    default: supported = 1'b0;
                endcase
            end
            `OP_IMM, `OP_LOAD: begin
                supported = (opcode == `OP_IMM) ? funct3 == 3'b000 : funct3 == 3'b011;
                next.regWrite = 1'b1;
                next.memRead = (opcode == `OP_LOAD);
                next.useImm = 1'b1;
                next.imm = {{52{instr[31]}}, instr[31:20]};
            end
            `OP_STORE: begin
                supported = (funct3 == 3'b011);
                next.memWrite = 1'b1;
                next.useImm = 1'b1;
                next.imm = {{52{instr[31]}}, instr[31:25], instr[11:7]};
            end
            `OP_BRANCH: begin
                supported = (funct3 == 3'b000);
                next.isBranch = 1'b1;
                next.imm = {{51{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            end
            `OP_JAL: begin
                supported = 1'b1;
                next.regWrite = 1'b1;
                next.isJal = 1'b1;
                next.imm = {{43{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            end
            default: ;
        endcase
        next.valid = moduleIn.valid && supported;
        // x0 is never a destination.
        next.regWrite = next.regWrite && rdAddr != 5'd0;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            moduleOut.valid <= 1'b0;
        end else if (okAll) begin
            // A redirect or a load-use hold turns this slot into a bubble.
            moduleOut <= next;
            moduleOut.valid <= next.valid && !jumpEn && !lwHold;
        end
    end

endmodule

//--- verilog/execute.sv
module execute import corePkg::*; (
    input logic clk,
    input logic rstN,
    input logic okAll,
    input regIdEx_t moduleIn,
    output regExMem_t moduleOut,
    output fwdSource_t fwdEx,
    output logic jumpEn,
    output u64 jumpAddr,
    output logic okToProceed
);

    u64 opB;
    u64 aluOut;
    u64 result;

    assign opB = moduleIn.useImm ? moduleIn.imm : moduleIn.op2;

    always_comb begin
        case (moduleIn.aluOp)
            ALU_SUB: aluOut = moduleIn.op1 - opB;
            ALU_AND: aluOut = moduleIn.op1 & opB;
            ALU_OR:  aluOut = moduleIn.op1 | opB;
            ALU_XOR: aluOut = moduleIn.op1 ^ opB;
            default: aluOut = moduleIn.op1 + opB;
        endcase
    end

    // JAL links the address of the next instruction.
    assign result = moduleIn.isJal ? moduleIn.pc + 64'd4 : aluOut;

    assign jumpEn = moduleIn.valid
        && (moduleIn.isJal || (moduleIn.isBranch && moduleIn.op1 == moduleIn.op2));
    assign jumpAddr = moduleIn.pc + moduleIn.imm;

    // For a load the data is not known yet, so decode waits on isLoad.
    always_comb begin
        fwdEx.valid = moduleIn.valid && moduleIn.regWrite;
        fwdEx.rd = moduleIn.rd;
        fwdEx.data = result;
        fwdEx.isLoad = moduleIn.memRead;
    end

    assign okToProceed = 1'b1;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            moduleOut.valid <= 1'b0;
        end else if (okAll) begin
            moduleOut.valid <= moduleIn.valid;
            moduleOut.pc <= moduleIn.pc;
            moduleOut.rd <= moduleIn.rd;
            moduleOut.regWrite <= moduleIn.regWrite;
            moduleOut.memRead <= moduleIn.memRead;
            moduleOut.memWrite <= moduleIn.memWrite;
            moduleOut.aluResult <= result;
            moduleOut.storeData <= moduleIn.storeData;
        end
    end

endmodule

//--- verilog/memory.sv
module memory import corePkg::*; (
    input logic clk,
    input logic rstN,
    input logic okAll,
    input regExMem_t moduleIn,
    output regMemWb_t moduleOut,
    output fwdSource_t fwdMem,
    output logic dreqValid,
    output logic dreqWrite,
    output u64 dreqAddr,
    output u64 dreqData,
    input logic drespOk,
    input u64 drespData,
    output logic okToProceed
);

    logic memOp;
    logic reqPending;
    logic done;
    logic respNow;
    u64 loadData;
    u64 result;

    assign memOp = moduleIn.valid && (moduleIn.memRead || moduleIn.memWrite);
    assign respNow = reqPending && drespOk;
    assign dreqValid = reqPending;
    assign okToProceed = !memOp || done || respNow;

    assign result = !moduleIn.memRead ? moduleIn.aluResult : done ? loadData : drespData;

    always_comb begin
        fwdMem.valid = moduleIn.valid && moduleIn.regWrite;
        fwdMem.rd = moduleIn.rd;
        fwdMem.data = result;
        fwdMem.isLoad = moduleIn.memRead;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            reqPending <= 1'b0;
            done <= 1'b0;
            moduleOut.valid <= 1'b0;
        end else begin
            if (okAll) begin
                moduleOut.valid <= moduleIn.valid;
                moduleOut.pc <= moduleIn.pc;
                moduleOut.rd <= moduleIn.rd;
                moduleOut.regWrite <= moduleIn.regWrite;
                moduleOut.result <= result;
                done <= 1'b0;
            end else if (respNow) begin
                done <= 1'b1;
            end
            if (respNow) begin
                reqPending <= 1'b0;
                loadData <= drespData;
            end else if (memOp && !reqPending && !done) begin
                // Each access goes out once and stays put until its response.
                reqPending <= 1'b1;
                dreqWrite <= moduleIn.memWrite;
                dreqAddr <= moduleIn.aluResult;
                dreqData <= moduleIn.storeData;
            end
        end
    end

endmodule

//--- verilog/program_counter.sv
`include "core_consts.svh"

module programCounter import corePkg::*; (
    input logic clk,
    input logic rstN,
    input logic lwHold,
    input logic okAll,
    input logic jumpEn,
    input u64 jumpAddr,
    output logic ireqValid,
    output u64 ireqAddr,
    input logic irespOk,
    input u32 irespData,
    output logic okToProceed,
    output regIfId_t moduleOut
);

    u64 pc;
    logic haveInstr;
    u32 instrLatch;
    u32 curInstr;

    assign ireqAddr = pc;
    assign curInstr = haveInstr ? instrLatch : irespData;
    assign okToProceed = haveInstr || (ireqValid && irespOk);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= `RESET_PC;
            ireqValid <= 1'b0;
            haveInstr <= 1'b0;
            moduleOut.valid <= 1'b0;
        end else if (okAll && !lwHold) begin
            moduleOut.valid <= !jumpEn;
            moduleOut.pc <= pc;
            moduleOut.instr <= jumpEn ? `NOP_INSTR : curInstr;
            pc <= jumpEn ? jumpAddr : pc + 64'd4;
            ireqValid <= 1'b1;
            haveInstr <= 1'b0;
        end else if (ireqValid && irespOk) begin
            // Keep the word until the pipeline is able to take it.
            instrLatch <= irespData;
            haveInstr <= 1'b1;
            ireqValid <= 1'b0;
        end else if (!ireqValid && !haveInstr) begin
            ireqValid <= 1'b1;
        end
    end

endmodule

//--- verilog/reg_read_if.sv
`include "core_consts.svh"

interface regReadIf;

    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;

    // Decode drives the addresses and reads the data back in the same cycle.
    modport client (
        output rs1, rs2,
        input  rs1Data, rs2Data
    );

    modport server (
        input  rs1, rs2,
        output rs1Data, rs2Data
    );

endinterface

//--- verilog/regfile.sv
module regfile import corePkg::*; (
    input logic clk,
    input logic rstN,
    regReadIf.server rd,
    input logic wbEn,
    input u5 wd,
    input u64 wbData
);

    u64 regs [1:31];

    // A write in progress is visible to a read of the same register.
    function automatic u64 readPort(input u5 addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (wbEn && wd == addr) begin
            return wbData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rd.rs1Data = readPort(rd.rs1);
        rd.rs2Data = readPort(rd.rs2);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && wd != 5'd0) begin
            regs[wd] <= wbData;
        end
    end

endmodule

//--- verilog/writeback.sv
module writeback import corePkg::*; (
    input logic clk,
    input logic rstN,
    input logic okAll,
    input regMemWb_t moduleIn,
    output logic wbEn,
    output u5 wd,
    output u64 wbData,
    output commit_t commit,
    output logic okToProceed
);

    assign wbEn = moduleIn.valid && moduleIn.regWrite && okAll;
    assign wd = moduleIn.rd;
    assign wbData = moduleIn.result;
    assign okToProceed = 1'b1;

    // One record per retired instruction, a cycle after its register write.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            commit.valid <= 1'b0;
        end else begin
            commit.valid <= moduleIn.valid && okAll;
            commit.pc <= moduleIn.pc;
            commit.rd <= moduleIn.rd;
            commit.regWrite <= moduleIn.regWrite;
            commit.data <= moduleIn.result;
        end
    end

endmodule
